/* nes_mem_pkg.sv */
/*
 * NES memory subsystem shared definitions
 * address widths, the RAM request and button structs, bridge states
 */

package nes_mem_pkg;

    ////////////////////////////////////////
    // address widths
    ////////////////////////////////////////

    localparam int NES_ADDR_W = 22;    // console byte address
    localparam int RV_ADDR_W  = 23;    // softcore byte address

    typedef logic [NES_ADDR_W-1:0] nes_addr_t;

    ////////////////////////////////////////
    // RAM access
    ////////////////////////////////////////

    // one 16-bit access, addr is a word address (byte address / 2)
    typedef struct packed {
        logic [NES_ADDR_W-1:0] addr;
        logic [15:0]           wdata;
        logic [1:0]            be;       // bit 0 is the low byte lane
        logic                  we;
    } mem_req_t;

    // console button order, right is the msb
    typedef struct packed {
        logic right;
        logic left;
        logic down;
        logic up;
        logic start;
        logic select;
        logic b;
        logic a;
    } nes_btn_t;

    // softcore word bridge FSM
    typedef enum logic [2:0] {
        rv_idle,
        rv_wait_lo,
        rv_data_lo,
        rv_wait_hi,
        rv_data_hi
    } rv_state_e;

endpackage

/* rom_loader.sv */
/*
 * ROM loader
 * turns the incoming byte stream into sequential one-lane RAM writes
 * and holds the console in reset while a game is loading
 */

`timescale 1ns/100ps

module rom_loader (
    input  logic                 clk,
    input  logic                 sys_resetn,
    input  logic                 i_loading,
    input  logic                 i_load_valid,
    input  logic [7:0]           i_load_data,
    output nes_mem_pkg::mem_req_t o_req,
    output logic                 o_req_valid,
    output logic                 o_reset_nes
);
    import nes_mem_pkg::*;

    logic      loading_q;
    logic      load_rise;
    logic      load_fall;
    nes_addr_t byte_cnt;
    nes_addr_t byte_addr;

    assign load_rise = i_loading & ~loading_q;
    assign load_fall = ~i_loading & loading_q;

    // first byte of a load lands at address 0 even on the rising cycle
    assign byte_addr = load_rise ? '0 : byte_cnt;

    assign o_req_valid = i_load_valid & i_loading;
    assign o_req.addr  = {1'b0, byte_addr[NES_ADDR_W-1:1]};
    assign o_req.wdata = {2{i_load_data}};
    assign o_req.be    = byte_addr[0] ? 2'b10 : 2'b01;
    assign o_req.we    = 1'b1;

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            loading_q   <= 1'b0;
            byte_cnt    <= '0;
            o_reset_nes <= 1'b1;
        end else begin
            loading_q <= i_loading;
            if (o_req_valid)
                byte_cnt <= byte_addr + 1'b1;
            else if (load_rise)
                byte_cnt <= '0;
            if (load_rise)
                o_reset_nes <= 1'b1;   // hold console while loading
            else if (load_fall)
                o_reset_nes <= 1'b0;
        end
    end

endmodule

/* rv_word_bridge.sv */
/*
 * Softcore word bridge
 * splits 32-bit bus accesses into two 16-bit halves over a toggle
 * request/acknowledge pair, skipping halves with no write strobes
 */

`timescale 1ns/100ps

module rv_word_bridge (
    input  logic                                 clk,
    input  logic                                 sys_resetn,
    input  logic                                 i_rv_valid,
    input  logic [nes_mem_pkg::RV_ADDR_W-1:0]    i_rv_addr,
    input  logic [31:0]                          i_rv_wdata,
    input  logic [3:0]                           i_rv_wstrb,
    output logic [31:0]                          o_rv_rdata,
    output logic                                 o_rv_ready,
    output nes_mem_pkg::mem_req_t                o_req,
    output logic                                 o_req_tgl,
    input  logic                                 i_ack_tgl,
    input  logic [15:0]                          i_half_rdata
);
    import nes_mem_pkg::*;

    rv_state_e   state;
    logic        valid_q;
    logic        new_req;       // rising edge seen while busy
    logic        new_req_now;
    logic        is_write;
    logic        hi_word;       // which half is on the bus
    logic [1:0]  half_be;
    logic        acked;
    logic [15:0] lo_half_q;

    assign new_req_now = i_rv_valid & ~valid_q;
    assign is_write    = |i_rv_wstrb;
    assign acked       = (o_req_tgl == i_ack_tgl);

    assign o_req.addr  = {i_rv_addr[RV_ADDR_W-1:2], hi_word};
    assign o_req.wdata = hi_word ? i_rv_wdata[31:16] : i_rv_wdata[15:0];
    assign o_req.be    = half_be;
    assign o_req.we    = is_write;

    assign o_rv_rdata = {i_half_rdata, lo_half_q};  // upper half held by arbiter

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            state      <= rv_idle;
            valid_q    <= 1'b0;
            new_req    <= 1'b0;
            o_req_tgl  <= 1'b0;
            o_rv_ready <= 1'b0;
            hi_word    <= 1'b0;
            half_be    <= 2'b00;
        end else begin
            valid_q    <= i_rv_valid;
            o_rv_ready <= 1'b0;
            if (new_req_now)
                new_req <= 1'b1;

            case (state)
                rv_idle: if (new_req || new_req_now) begin
                    new_req   <= 1'b0;
                    o_req_tgl <= ~o_req_tgl;
                    if (is_write && i_rv_wstrb[1:0] == 2'b00) begin
                        hi_word <= 1'b1;                  // upper half only
                        half_be <= i_rv_wstrb[3:2];
                        state   <= rv_wait_hi;
                    end else begin
                        hi_word <= 1'b0;
                        half_be <= is_write ? i_rv_wstrb[1:0] : 2'b11;
                        state   <= rv_wait_lo;
                    end
                end
                rv_wait_lo: if (acked) begin
                    if (!is_write) begin
                        state <= rv_data_lo;
                    end else if (i_rv_wstrb[3:2] == 2'b00) begin
                        o_rv_ready <= 1'b1;               // lower half only
                        state      <= rv_idle;
                    end else begin
                        o_req_tgl <= ~o_req_tgl;
                        hi_word   <= 1'b1;
                        half_be   <= i_rv_wstrb[3:2];
                        state     <= rv_wait_hi;
                    end
                end
                rv_data_lo: begin
                    o_req_tgl <= ~o_req_tgl;   // low half latched so ask for the high one
                    hi_word   <= 1'b1;
                    half_be   <= 2'b11;
                    state     <= rv_wait_hi;
                end
                rv_wait_hi: if (acked) begin
                    if (is_write) begin
                        o_rv_ready <= 1'b1;
                        state      <= rv_idle;
                    end else begin
                        state <= rv_data_hi;
                    end
                end
                rv_data_hi: begin
                    o_rv_ready <= 1'b1;
                    state      <= rv_idle;
                end
                default: state <= rv_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == rv_data_lo)
            lo_half_q <= i_half_rdata;
    end

    // ready only once every half of the request has been acknowledged
    a_one_ready: assert property (@(posedge clk) disable iff (!sys_resetn)
        o_rv_ready |-> acked);

endmodule

/* mem_arbiter.sv */
/*
 * Memory arbiter
 * fixed priority loader > CPU > softcore bridge, one access per clock,
 * returns read data to the CPU byte or the bridge half
 */

`timescale 1ns/100ps

module mem_arbiter #(
    parameter int ADDR_W = 12
) (
    input  logic                  clk,
    input  logic                  sys_resetn,
    input  logic                  i_loading,
    input  nes_mem_pkg::mem_req_t i_loader_req,
    input  logic                  i_loader_valid,
    input  nes_mem_pkg::mem_req_t i_cpu_req,
    input  logic                  i_cpu_valid,
    input  logic                  i_cpu_byte_sel,
    input  nes_mem_pkg::mem_req_t i_rv_req,
    input  logic                  i_rv_req_tgl,
    output logic                  o_rv_ack_tgl,
    output logic [15:0]           o_rv_rdata,
    output logic [7:0]            o_cpu_dout,
    output nes_mem_pkg::mem_req_t o_mem_req,
    output logic                  o_mem_valid,
    input  logic [15:0]           i_mem_rdata
);
    import nes_mem_pkg::*;

    mem_req_t sel_req;
    logic     cpu_grant;
    logic     rv_grant;
    logic     cpu_rd_q;     // CPU read in flight
    logic     cpu_sel_q;
    logic     rv_rd_q;      // bridge read in flight

    assign cpu_grant = i_cpu_valid & ~i_loading;   // CPU is off the bus while loading
    assign rv_grant  = (i_rv_req_tgl != o_rv_ack_tgl) & ~i_loader_valid & ~cpu_grant;

    always_comb begin
        if (i_loader_valid)
            sel_req = i_loader_req;
        else if (cpu_grant)
            sel_req = i_cpu_req;
        else
            sel_req = i_rv_req;
        o_mem_req      = sel_req;
        o_mem_req.addr = '0;
        o_mem_req.addr[ADDR_W-1:0] = sel_req.addr[ADDR_W-1:0];
    end

    assign o_mem_valid = i_loader_valid | cpu_grant | rv_grant;

    ////////////////////////////////////////
    // read return
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            o_rv_ack_tgl <= 1'b0;
            cpu_rd_q     <= 1'b0;
            rv_rd_q      <= 1'b0;
        end else begin
            cpu_rd_q <= cpu_grant & ~i_cpu_req.we;
            rv_rd_q  <= rv_grant & ~i_rv_req.we;
            if (rv_grant)
                o_rv_ack_tgl <= ~o_rv_ack_tgl;
        end
    end

    // RAM data is valid the cycle after the grant
    always_ff @(posedge clk) begin
        cpu_sel_q <= i_cpu_byte_sel;
        if (cpu_rd_q)
            o_cpu_dout <= cpu_sel_q ? i_mem_rdata[15:8] : i_mem_rdata[7:0];
        if (rv_rd_q)
            o_rv_rdata <= i_mem_rdata;
    end

    // loader writes only happen with i_loading high
    a_no_loader_cpu: assert property (@(posedge clk) disable iff (!sys_resetn)
        !(i_loader_valid && cpu_grant));

endmodule

/* shared_ram.sv */
/*
 * Shared on-chip RAM
 * single port, 16-bit words with byte lanes, registered read
 */

`timescale 1ns/100ps

module shared_ram #(
    parameter int ADDR_W = 12
) (
    input  logic                  clk,
    input  nes_mem_pkg::mem_req_t i_req,
    input  logic                  i_valid,
    output logic [15:0]           o_rdata
);
    import nes_mem_pkg::*;

    logic [15:0]       mem [2**ADDR_W];
    logic [ADDR_W-1:0] waddr;

    assign waddr = i_req.addr[ADDR_W-1:0];

    if (ADDR_W > NES_ADDR_W) begin : g_bad_depth
        $error("RAM depth exceeds the console address space");
    end

    always_ff @(posedge clk) begin
        if (i_valid) begin
            if (i_req.we) begin
                if (i_req.be[0])
                    mem[waddr][7:0] <= i_req.wdata[7:0];
                if (i_req.be[1])
                    mem[waddr][15:8] <= i_req.wdata[15:8];
            end else begin
                o_rdata <= mem[waddr];  // held until the next read
            end
        end
    end

endmodule

/* joypad_port.sv */
/*
 * Player one joypad port
 * maps Dualshock receive bytes to console buttons and shifts them
 * out on the console strobe and clock
 */

`timescale 1ns/100ps

module joypad_port (
    input  logic       clk,
    input  logic       sys_resetn,
    input  logic [7:0] i_ps_rx0,
    input  logic [7:0] i_ps_rx1,
    input  logic       i_joypad_strobe,
    input  logic       i_joypad_clock,
    output logic       o_joypad_data
);
    import nes_mem_pkg::*;

    nes_btn_t   btn;
    logic [7:0] shift_q;
    logic       pad_clk_q;
    logic       pad_clk_fall;

    ////////////////////////////////////////
    // button mapping
    ////////////////////////////////////////

    // Dualshock bits are active low
    always_comb begin
        btn.right  = ~i_ps_rx0[5];
        btn.left   = ~i_ps_rx0[7];
        btn.down   = ~i_ps_rx0[6];
        btn.up     = ~i_ps_rx0[4];
        btn.start  = ~i_ps_rx0[3];
        btn.select = ~i_ps_rx0[0];
        btn.b      = ~i_ps_rx1[6];   // cross
        btn.a      = ~i_ps_rx1[5];   // circle
    end

    assign pad_clk_fall = ~i_joypad_clock & pad_clk_q;

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            shift_q   <= 8'h00;
            pad_clk_q <= 1'b0;
        end else begin
            pad_clk_q <= i_joypad_clock;
            if (i_joypad_strobe)
                shift_q <= btn;
            else if (pad_clk_fall)
                shift_q <= {1'b0, shift_q[7:1]};   // a goes out first
        end
    end

    assign o_joypad_data = shift_q[0];

endmodule

/* nes_mem_top.sv */
/*
 * NES memory subsystem top level
 * loader, CPU port and softcore bridge share one RAM, plus the
 * first player's joypad path
 */

`timescale 1ns/100ps

module nes_mem_top #(
    parameter int ADDR_W = 12
) (
    input  logic                              clk,
    input  logic                              sys_resetn,
    input  logic                              i_loading,
    input  logic                              i_load_valid,
    input  logic [7:0]                        i_load_data,
    input  nes_mem_pkg::nes_addr_t            i_cpu_addr,
    input  logic                              i_cpu_read,
    input  logic                              i_cpu_write,
    input  logic [7:0]                        i_cpu_wdata,
    output logic [7:0]                        o_cpu_dout,
    input  logic                              i_rv_valid,
    input  logic [nes_mem_pkg::RV_ADDR_W-1:0] i_rv_addr,
    input  logic [31:0]                       i_rv_wdata,
    input  logic [3:0]                        i_rv_wstrb,
    output logic [31:0]                       o_rv_rdata,
    output logic                              o_rv_ready,
    input  logic [7:0]                        i_ps_rx0,
    input  logic [7:0]                        i_ps_rx1,
    input  logic                              i_joypad_strobe,
    input  logic                              i_joypad_clock,
    output logic                              o_joypad_data,
    output logic                              o_reset_nes
);
    import nes_mem_pkg::*;

    mem_req_t    loader_req, cpu_req, rv_req, mem_req;
    logic        loader_valid, cpu_valid, mem_valid;
    logic        rv_req_tgl, rv_ack_tgl;
    logic [15:0] rv_half_rdata, mem_rdata;

    // CPU byte access as a one-lane word request
    assign cpu_valid     = i_cpu_read | i_cpu_write;
    assign cpu_req.addr  = {1'b0, i_cpu_addr[NES_ADDR_W-1:1]};
    assign cpu_req.wdata = {2{i_cpu_wdata}};
    assign cpu_req.be    = i_cpu_addr[0] ? 2'b10 : 2'b01;
    assign cpu_req.we    = i_cpu_write;

    rom_loader i_rom_loader (
        .clk(clk), .sys_resetn(sys_resetn),
        .i_loading(i_loading), .i_load_valid(i_load_valid), .i_load_data(i_load_data),
        .o_req(loader_req), .o_req_valid(loader_valid), .o_reset_nes(o_reset_nes)
    );

    rv_word_bridge i_rv_word_bridge (
        .clk(clk), .sys_resetn(sys_resetn),
        .i_rv_valid(i_rv_valid), .i_rv_addr(i_rv_addr), .i_rv_wdata(i_rv_wdata),
        .i_rv_wstrb(i_rv_wstrb), .o_rv_rdata(o_rv_rdata), .o_rv_ready(o_rv_ready),
        .o_req(rv_req), .o_req_tgl(rv_req_tgl), .i_ack_tgl(rv_ack_tgl),
        .i_half_rdata(rv_half_rdata)
    );

    mem_arbiter #(.ADDR_W(ADDR_W)) i_mem_arbiter (
        .clk(clk), .sys_resetn(sys_resetn), .i_loading(i_loading),
        .i_loader_req(loader_req), .i_loader_valid(loader_valid),
        .i_cpu_req(cpu_req), .i_cpu_valid(cpu_valid), .i_cpu_byte_sel(i_cpu_addr[0]),
        .i_rv_req(rv_req), .i_rv_req_tgl(rv_req_tgl), .o_rv_ack_tgl(rv_ack_tgl),
        .o_rv_rdata(rv_half_rdata), .o_cpu_dout(o_cpu_dout),
        .o_mem_req(mem_req), .o_mem_valid(mem_valid), .i_mem_rdata(mem_rdata)
    );

    shared_ram #(.ADDR_W(ADDR_W)) i_shared_ram (
        .clk(clk), .i_req(mem_req), .i_valid(mem_valid), .o_rdata(mem_rdata)
    );

    joypad_port i_joypad_port (
        .clk(clk), .sys_resetn(sys_resetn),
        .i_ps_rx0(i_ps_rx0), .i_ps_rx1(i_ps_rx1),
        .i_joypad_strobe(i_joypad_strobe), .i_joypad_clock(i_joypad_clock),
        .o_joypad_data(o_joypad_data)
    );

endmodule

/* tb_nes_mem_top.sv */
/*
 * NES memory subsystem testbench
 * directed tests over loader, CPU port, softcore bridge and joypad
 */

`timescale 1ns/100ps

module tb_nes_mem_top;
    import nes_mem_pkg::*;

    localparam int CLK_PERIOD       = 40;
    localparam int RV_WAIT_MAX      = 32;   // cycles allowed for one softcore ready
    localparam int RV_ACCESS_CYCLES = RV_WAIT_MAX + 5;
    localparam int TEST_CYCLES      = 10 + 12 + 80 + 25 + (2 * RV_ACCESS_CYCLES + 12)
                                      + 4 * RV_ACCESS_CYCLES + 25;
    localparam int MARGIN_CYCLES    = 100;
    localparam logic [RV_ADDR_W-1:0] RV_BASE = 23'h000100;

    logic                 clk;
    logic                 sys_resetn;
    logic                 i_loading, i_load_valid;
    logic [7:0]           i_load_data;
    nes_addr_t            i_cpu_addr;
    logic                 i_cpu_read, i_cpu_write;
    logic [7:0]           i_cpu_wdata, o_cpu_dout;
    logic                 i_rv_valid, o_rv_ready;
    logic [RV_ADDR_W-1:0] i_rv_addr;
    logic [31:0]          i_rv_wdata, o_rv_rdata;
    logic [3:0]           i_rv_wstrb;
    logic [7:0]           i_ps_rx0, i_ps_rx1;
    logic                 i_joypad_strobe, i_joypad_clock, o_joypad_data;
    logic                 o_reset_nes;

    int          errors = 0;
    int          checks = 0;
    logic [31:0] rand_state = 32'd25032;
    logic [7:0]  load_buf [16];

    nes_mem_top #(.ADDR_W(12)) i_nes_mem_top (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    function automatic logic [31:0] lcg_next();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state;
    endfunction

    // inputs change 2 ns after the edge and outputs are read at the same point
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic cpu_write(input nes_addr_t addr, input logic [7:0] data);
        i_cpu_addr  = addr;
        i_cpu_wdata = data;
        i_cpu_write = 1'b1;
        next_cycle();
        i_cpu_write = 1'b0;
    endtask

    task automatic cpu_read_check(input nes_addr_t addr, input logic [7:0] exp);
        i_cpu_addr = addr;
        i_cpu_read = 1'b1;
        next_cycle();
        i_cpu_read = 1'b0;
        next_cycle();   // byte is out two cycles after the strobe
        check_val("o_cpu_dout", o_cpu_dout, exp);
    endtask

    // one softcore access with exactly one ready pulse expected
    task automatic rv_access(input logic [31:0] wdata, input logic [3:0] wstrb,
                             output logic [31:0] rdata);
        int waited;
        int extra;
        waited     = 0;
        extra      = 0;
        rdata      = 'x;
        i_rv_addr  = RV_BASE;
        i_rv_wdata = wdata;
        i_rv_wstrb = wstrb;
        i_rv_valid = 1'b1;
        next_cycle();
        while (o_rv_ready !== 1'b1 && waited < RV_WAIT_MAX) begin
            next_cycle();
            waited++;
        end
        checks++;
        assert (o_rv_ready === 1'b1) else begin
            errors++;
            $display("softcore access with strobes %b saw no ready within %0d cycles",
                     wstrb, RV_WAIT_MAX);
        end
        rdata      = o_rv_rdata;
        i_rv_valid = 1'b0;
        repeat (3) begin
            next_cycle();
            if (o_rv_ready === 1'b1)
                extra++;
        end
        check_val("o_rv_ready pulses", 1 + extra, 1);
    endtask

    task automatic pad_clock_fall();
        i_joypad_clock = 1'b1;
        next_cycle();
        i_joypad_clock = 1'b0;
        next_cycle();
    endtask

    ////////////////////////////////////////
    // tests
    ////////////////////////////////////////

    task automatic reset_and_loading();
        check_val("o_reset_nes", o_reset_nes, 1);
        check_val("o_rv_ready", o_rv_ready, 0);
        check_val("o_joypad_data", o_joypad_data, 0);
        i_loading = 1'b1;
        repeat (3) next_cycle();
        check_val("o_reset_nes", o_reset_nes, 1);
        i_loading = 1'b0;
        next_cycle();
        check_val("o_reset_nes", o_reset_nes, 0);
    endtask

    task automatic load_and_read();
        logic [31:0] r;
        i_loading = 1'b1;
        next_cycle();
        check_val("o_reset_nes", o_reset_nes, 1);
        for (int i = 0; i < 16; i++) begin
            r           = lcg_next();
            load_buf[i] = r[23:16];
            i_load_data  = r[23:16];
            i_load_valid = 1'b1;
            next_cycle();
            i_load_valid = 1'b0;
            next_cycle();
        end
        i_loading = 1'b0;
        next_cycle();
        check_val("o_reset_nes", o_reset_nes, 0);
        for (int i = 0; i < 16; i++)
            cpu_read_check(nes_addr_t'(i), load_buf[i]);
    endtask

    task automatic cpu_lane_writes();
        cpu_write(22'h000041, 8'h5a);   // odd byte in the upper lane
        cpu_write(22'h000040, 8'hc3);
        cpu_read_check(22'h000041, 8'h5a);
        cpu_read_check(22'h000040, 8'hc3);
        cpu_write(22'h000041, 8'h96);
        cpu_read_check(22'h000040, 8'hc3);
        cpu_read_check(22'h000041, 8'h96);
    endtask

    task automatic rv_full_word(output logic [31:0] word);
        logic [31:0] rd;
        word = lcg_next();
        rv_access(word, 4'b1111, rd);
        rv_access(32'h0, 4'b0000, rd);
        check_val("o_rv_rdata", rd, word);
        for (int i = 0; i < 4; i++)
            cpu_read_check(nes_addr_t'(RV_BASE + i), word[8*i +: 8]);
    endtask

    task automatic rv_partial_strobes(input logic [31:0] old_word);
        logic [31:0] upper;
        logic [31:0] lower;
        logic [31:0] rd;
        upper = lcg_next();
        lower = lcg_next();
        rv_access(upper, 4'b1100, rd);
        rv_access(32'h0, 4'b0000, rd);
        check_val("o_rv_rdata", rd, {upper[31:16], old_word[15:0]});
        rv_access(lower, 4'b0011, rd);
        rv_access(32'h0, 4'b0000, rd);
        check_val("o_rv_rdata", rd, {upper[31:16], lower[15:0]});
    endtask

    task automatic joypad_shift();
        logic [31:0] r0;
        logic [31:0] r1;
        logic [7:0]  order;   // bit k leaves on the k-th read
        int          k;
        r0 = lcg_next();
        r1 = lcg_next();
        order[0] = ~r1[21];   // a from rx1 bit 5
        order[1] = ~r1[22];   // b from rx1 bit 6
        order[2] = ~r0[16];   // select
        order[3] = ~r0[19];   // start
        order[4] = ~r0[20];   // up
        order[5] = ~r0[22];   // down
        order[6] = ~r0[23];   // left
        order[7] = ~r0[21];   // right
        i_ps_rx0        = r0[23:16];
        i_ps_rx1        = r1[23:16];
        i_joypad_strobe = 1'b1;
        next_cycle();
        i_joypad_strobe = 1'b0;
        check_val("o_joypad_data", o_joypad_data, order[0]);
        for (k = 1; k < 10; k++) begin
            pad_clock_fall();
            check_val("o_joypad_data", o_joypad_data, (k < 8) ? order[k] : 1'b0);
        end
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        logic [31:0] word;
        sys_resetn      = 1'b0;
        i_loading       = 1'b0;
        i_load_valid    = 1'b0;
        i_load_data     = 8'h00;
        i_cpu_addr      = '0;
        i_cpu_read      = 1'b0;
        i_cpu_write     = 1'b0;
        i_cpu_wdata     = 8'h00;
        i_rv_valid      = 1'b0;
        i_rv_addr       = '0;
        i_rv_wdata      = 32'h0;
        i_rv_wstrb      = 4'h0;
        i_ps_rx0        = 8'hff;   // nothing pressed
        i_ps_rx1        = 8'hff;
        i_joypad_strobe = 1'b0;
        i_joypad_clock  = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        sys_resetn = 1'b1;

        reset_and_loading();
        load_and_read();
        cpu_lane_writes();
        rv_full_word(word);
        rv_partial_strobes(word);
        joypad_shift();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    initial begin
        #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("run stopped by the watchdog, tests did not finish in time");
        $display("checks: %0d, errors: %0d", checks, errors + 1);
        $display("Some tests failed");
        $finish;
    end

endmodule

/* flist.f */
nes_mem_pkg.sv
rom_loader.sv
rv_word_bridge.sv
mem_arbiter.sv
shared_ram.sv
joypad_port.sv
nes_mem_top.sv
tb_nes_mem_top.sv
